/* hw/adcfifo_pkg.sv */
package adcfifo_pkg;

  // buffer geometry, 256 entries
  localparam int BUF_AW = 8;

  // fill levels for the lap detector
  localparam logic [BUF_AW-1:0] BUF_THRESHOLD_LO = 8'd6;
  localparam logic [BUF_AW-1:0] BUF_THRESHOLD_HI = 8'd250;

  // entries per burst, tied to the 2-bit pointer phase
  localparam int BURST_BEATS = 4;

  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    EXOKAY = 2'b01,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } axi_resp_e;

  typedef enum logic {
    AW_IDLE,
    AW_VALID
  } aw_state_e;

  function automatic logic [7:0] bin2gray(input logic [7:0] b);
    return b ^ (b >> 1);
  endfunction

  function automatic logic [7:0] gray2bin(input logic [7:0] g);
    logic [7:0] b;
    b[7] = g[7];
    for (int i = 6; i >= 0; i--) begin
      b[i] = b[i+1] ^ g[i];
    end
    return b;
  endfunction

endpackage

/* hw/adcfifo_dual_port_ram.sv */
`timescale 1ns/10ps

module adcfifo_dual_port_ram #(
  parameter int DATA_WIDTH = 64,
  parameter int ADDR_WIDTH = 8
) (
  input  logic                  wr_clk,
  input  logic                  wr_en,
  input  logic [ADDR_WIDTH-1:0] wr_addr,
  input  logic [DATA_WIDTH-1:0] wr_data,
  input  logic                  rd_clk,
  input  logic [ADDR_WIDTH-1:0] rd_addr,
  output logic [DATA_WIDTH-1:0] rd_data
);

  logic [DATA_WIDTH-1:0] mem [0:(2**ADDR_WIDTH)-1];

  // write port, adc side
  always_ff @(posedge wr_clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // read port, one cycle of latency
  always_ff @(posedge rd_clk) begin
    rd_data <= mem[rd_addr];
  end

endmodule

/* hw/adcfifo_capture.sv */
`timescale 1ns/10ps

module adcfifo_capture #(
  parameter logic [31:0] BASE_ADDR  = 32'h0000_0000,
  parameter logic [31:0] ADDR_LIMIT = 32'h0000_0fe0,
  parameter int          DATA_WIDTH = 64
) (
  input  logic                           adc_clk,
  input  logic                           adc_rst,
  input  logic                           dma_xfer_req,
  input  logic                           adc_wr,
  output logic                           wr_en,
  output logic [adcfifo_pkg::BUF_AW-1:0] wr_addr,
  output logic [adcfifo_pkg::BUF_AW-1:0] waddr_gray,
  output logic                           rel_toggle,
  output logic [adcfifo_pkg::BUF_AW-1:0] rel_waddr
);

  import adcfifo_pkg::*;

  localparam logic [31:0] BURST_INCR = 32'(BURST_BEATS * (DATA_WIDTH / 8));
  localparam logic [1:0]  GROUP_END  = 2'(BURST_BEATS - 1);

  logic [2:0]        xfer_req_m;
  logic              xfer_init;
  logic              xfer_limit;
  logic              xfer_enable;
  logic [31:0]       xfer_addr;
  logic [BUF_AW-1:0] waddr;
  logic              group_end;

  assign wr_en     = adc_wr & xfer_enable;
  assign wr_addr   = waddr;
  // last sample of a 4-entry group is being written
  assign group_end = wr_en && (waddr[1:0] == GROUP_END);

  // **********************************************************************
  // request sync and window control
  // **********************************************************************

  always_ff @(posedge adc_clk) begin
    if (adc_rst) begin
      xfer_req_m  <= '0;
      xfer_init   <= 1'b0;
      xfer_limit  <= 1'b0;
      xfer_enable <= 1'b0;
      xfer_addr   <= BASE_ADDR;
    end else begin
      xfer_req_m <= {xfer_req_m[1:0], dma_xfer_req};
      xfer_init  <= xfer_req_m[1] & ~xfer_req_m[2];

      // window still open
      if (xfer_init) begin
        xfer_limit <= 1'b1;
      end else if ((xfer_addr >= ADDR_LIMIT) || !xfer_enable) begin
        xfer_limit <= 1'b0;
      end

      // enable only changes on a group boundary
      if (xfer_init) begin
        xfer_enable <= 1'b1;
        xfer_addr   <= BASE_ADDR;
      end else if (group_end) begin
        xfer_enable <= xfer_req_m[2] & xfer_limit;
        xfer_addr   <= xfer_addr + BURST_INCR;
      end
    end
  end

  // **********************************************************************
  // write pointer and burst release
  // **********************************************************************

  always_ff @(posedge adc_clk) begin
    if (adc_rst) begin
      waddr      <= '0;
      waddr_gray <= '0;
      rel_toggle <= 1'b0;
      rel_waddr  <= '0;
    end else begin
      if (wr_en) begin
        waddr <= waddr + 1'b1;
      end
      waddr_gray <= bin2gray(waddr);

      // rel_waddr is stable before the toggle is seen on the axi side
      if (group_end) begin
        rel_toggle <= ~rel_toggle;
        rel_waddr  <= waddr + 1'b1;
      end
    end
  end

endmodule

/* hw/adcfifo_axi_writer.sv */
`timescale 1ns/10ps

module adcfifo_axi_writer #(
  parameter int          DATA_WIDTH = 64,
  parameter logic [31:0] BASE_ADDR  = 32'h0000_0000
) (
  input  logic                           axi_clk,
  input  logic                           axi_resetn,
  input  logic                           dma_xfer_req,
  input  logic [adcfifo_pkg::BUF_AW-1:0] waddr_gray,
  input  logic                           rel_toggle,
  input  logic [adcfifo_pkg::BUF_AW-1:0] rel_waddr,
  output logic [adcfifo_pkg::BUF_AW-1:0] rd_addr,
  input  logic [DATA_WIDTH-1:0]          rd_data,
  output logic                           beat_valid,
  output logic                           beat_last,
  output logic [DATA_WIDTH-1:0]          beat_data,
  input  logic                           beat_ready,
  output logic                           awvalid,
  output logic [31:0]                    awaddr,
  input  logic                           awready,
  input  logic                           bvalid,
  input  adcfifo_pkg::axi_resp_e         bresp,
  output logic                           werror,
  output logic                           dwovf,
  output logic                           dwunf,
  output logic                           rd_req,
  output logic [31:0]                    rd_addr_out
);

  import adcfifo_pkg::*;

  localparam logic [31:0] BURST_INCR = 32'(BURST_BEATS * (DATA_WIDTH / 8));

  logic [2:0]        rel_toggle_m;
  logic              rel_edge;
  logic [BUF_AW-1:0] rel_waddr_q;
  logic [BUF_AW-1:0] waddr_m1;
  logic [BUF_AW-1:0] waddr_m2;
  logic [BUF_AW-1:0] waddr_bin;
  logic [BUF_AW-1:0] addr_diff_s;
  logic [BUF_AW-1:0] addr_diff;
  logic              almost_full;
  logic              almost_empty;
  logic [2:0]        xfer_req_m;
  logic              xfer_init;
  logic [BUF_AW-1:0] raddr;
  logic              rd_s;
  logic              first_s;
  logic              last_s;
  logic              rd_q;
  logic              last_q;
  aw_state_e         aw_state;
  logic [BUF_AW-3:0] aw_pend;
  logic              aw_load;

  // **********************************************************************
  // clock crossing
  // **********************************************************************

  assign rel_edge = rel_toggle_m[2] ^ rel_toggle_m[1];

  always_ff @(posedge axi_clk or negedge axi_resetn) begin
    if (!axi_resetn) begin
      rel_toggle_m <= '0;
      rel_waddr_q  <= '0;
      waddr_m1     <= '0;
      waddr_m2     <= '0;
      waddr_bin    <= '0;
      xfer_req_m   <= '0;
      xfer_init    <= 1'b0;
    end else begin
      rel_toggle_m <= {rel_toggle_m[1:0], rel_toggle};
      if (rel_edge) begin
        rel_waddr_q <= rel_waddr;
      end
      waddr_m1   <= waddr_gray;
      waddr_m2   <= waddr_m1;
      waddr_bin  <= gray2bin(waddr_m2);
      xfer_req_m <= {xfer_req_m[1:0], dma_xfer_req};
      xfer_init  <= xfer_req_m[1] & ~xfer_req_m[2];
    end
  end

  // a jump across both fill thresholds means one side lapped the other
  assign addr_diff_s = waddr_bin - raddr;

  always_ff @(posedge axi_clk or negedge axi_resetn) begin
    if (!axi_resetn) begin
      addr_diff    <= '0;
      almost_full  <= 1'b0;
      almost_empty <= 1'b0;
      dwovf        <= 1'b0;
      dwunf        <= 1'b0;
    end else begin
      addr_diff    <= addr_diff_s;
      almost_full  <= addr_diff > BUF_THRESHOLD_HI;
      almost_empty <= addr_diff < BUF_THRESHOLD_LO;
      dwunf        <= (addr_diff > BUF_THRESHOLD_HI) && almost_empty;
      dwovf        <= (addr_diff < BUF_THRESHOLD_LO) && almost_full;
    end
  end

  // **********************************************************************
  // buffer read sequencing
  // **********************************************************************

  assign rd_s    = (rel_waddr_q != raddr) && beat_ready;
  assign first_s = rd_s && (raddr[1:0] == 2'd0);
  assign last_s  = rd_s && (raddr[1:0] == 2'd3);
  assign rd_addr = raddr;

  always_ff @(posedge axi_clk or negedge axi_resetn) begin
    if (!axi_resetn) begin
      raddr      <= '0;
      rd_q       <= 1'b0;
      last_q     <= 1'b0;
      beat_valid <= 1'b0;
      beat_last  <= 1'b0;
    end else begin
      if (rd_s) begin
        raddr <= raddr + 1'b1;
      end
      rd_q       <= rd_s;
      last_q     <= last_s;
      beat_valid <= rd_q;
      beat_last  <= last_q;
    end
  end

  // ram output lines up with rd_q
  always_ff @(posedge axi_clk) begin
    beat_data <= rd_data;
  end

  // **********************************************************************
  // address channel
  // **********************************************************************

  // bursts read ahead of a stalled awready wait in aw_pend
  assign aw_load = ((aw_state == AW_IDLE) || awready) && (first_s || (aw_pend != '0));
  assign awvalid = (aw_state == AW_VALID);

  always_ff @(posedge axi_clk or negedge axi_resetn) begin
    if (!axi_resetn) begin
      aw_state <= AW_IDLE;
      aw_pend  <= '0;
      awaddr   <= BASE_ADDR;
    end else begin
      case (aw_state)
        AW_IDLE: if (aw_load) aw_state <= AW_VALID;
        AW_VALID: if (awready && !aw_load) aw_state <= AW_IDLE;
        default: aw_state <= AW_IDLE;
      endcase
      if (first_s && !aw_load) begin
        aw_pend <= aw_pend + 1'b1;
      end else if (!first_s && aw_load) begin
        aw_pend <= aw_pend - 1'b1;
      end
      if (xfer_init) begin
        awaddr <= BASE_ADDR;
      end else if (awvalid && awready) begin
        awaddr <= awaddr + BURST_INCR;
      end
    end
  end

  // response check and read request stream
  always_ff @(posedge axi_clk or negedge axi_resetn) begin
    if (!axi_resetn) begin
      werror      <= 1'b0;
      rd_req      <= 1'b0;
      rd_addr_out <= BASE_ADDR;
    end else begin
      werror <= bvalid && ((bresp == SLVERR) || (bresp == DECERR));
      rd_req <= last_s;
      if (xfer_init) begin
        rd_addr_out <= BASE_ADDR;
      end else if (rd_req) begin
        rd_addr_out <= rd_addr_out + BURST_INCR;
      end
    end
  end

endmodule

/* hw/adcfifo_wdata_skid.sv */
`timescale 1ns/10ps

module adcfifo_wdata_skid #(
  parameter int DATA_WIDTH = 64
) (
  input  logic                  axi_clk,
  input  logic                  axi_resetn,
  input  logic                  beat_valid,
  input  logic                  beat_last,
  input  logic [DATA_WIDTH-1:0] beat_data,
  output logic                  beat_ready,
  output logic                  wvalid,
  output logic                  wlast,
  output logic [DATA_WIDTH-1:0] wdata,
  input  logic                  wready
);

  logic [1:0]            count;
  logic                  ready_q;
  logic                  push;
  logic                  pop;
  logic [DATA_WIDTH-1:0] data1;
  logic                  last1;

  assign push   = beat_valid;
  assign pop    = wvalid && wready;
  assign wvalid = (count != 2'd0);

  // stored entries, the beat arriving now and the one still in the ram stage
  assign beat_ready = ({1'b0, count} + 3'(beat_valid) + 3'(ready_q)) < 3'd2;

  always_ff @(posedge axi_clk or negedge axi_resetn) begin
    if (!axi_resetn) begin
      count   <= 2'd0;
      ready_q <= 1'b0;
    end else begin
      ready_q <= beat_ready;
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  // entry 0 is the head seen on the W channel
  always_ff @(posedge axi_clk) begin
    if (pop) begin
      wdata <= data1;
      wlast <= last1;
    end
    if (push && ((count == 2'd0) || (pop && (count == 2'd1)))) begin
      wdata <= beat_data;
      wlast <= beat_last;
    end
    if (push && (count != 2'd0) && !(pop && (count == 2'd1))) begin
      data1 <= beat_data;
      last1 <= beat_last;
    end
  end

endmodule

/* hw/adcfifo_wr.sv */
`timescale 1ns/10ps

module adcfifo_wr #(
  parameter int          DATA_WIDTH = 64,
  parameter logic [31:0] BASE_ADDR  = 32'h0000_0000,
  parameter logic [31:0] ADDR_LIMIT = 32'h0000_0fe0
) (
  input  logic                   axi_clk,
  input  logic                   axi_resetn,
  input  logic                   adc_clk,
  input  logic                   adc_rst,
  input  logic                   dma_xfer_req,
  input  logic                   adc_wr,
  input  logic [DATA_WIDTH-1:0]  adc_wdata,
  output logic                   awvalid,
  output logic [31:0]            awaddr,
  input  logic                   awready,
  output logic                   wvalid,
  output logic [DATA_WIDTH-1:0]  wdata,
  output logic                   wlast,
  input  logic                   wready,
  input  logic                   bvalid,
  input  adcfifo_pkg::axi_resp_e bresp,
  output logic                   rd_req,
  output logic [31:0]            rd_addr,
  output logic                   werror,
  output logic                   dwovf,
  output logic                   dwunf
);

  import adcfifo_pkg::*;

  logic              wr_en;
  logic [BUF_AW-1:0] wr_addr;
  logic [BUF_AW-1:0] waddr_gray;
  logic              rel_toggle;
  logic [BUF_AW-1:0] rel_waddr;
  logic [BUF_AW-1:0] ram_rd_addr;
  logic [DATA_WIDTH-1:0] ram_rd_data;
  logic              beat_valid;
  logic              beat_last;
  logic [DATA_WIDTH-1:0] beat_data;
  logic              beat_ready;

  // adc_clk domain
  adcfifo_capture #(
    .BASE_ADDR  (BASE_ADDR),
    .ADDR_LIMIT (ADDR_LIMIT),
    .DATA_WIDTH (DATA_WIDTH)
  ) u_capture (
    .adc_clk      (adc_clk),
    .adc_rst      (adc_rst),
    .dma_xfer_req (dma_xfer_req),
    .adc_wr       (adc_wr),
    .wr_en        (wr_en),
    .wr_addr      (wr_addr),
    .waddr_gray   (waddr_gray),
    .rel_toggle   (rel_toggle),
    .rel_waddr    (rel_waddr)
  );

  adcfifo_dual_port_ram #(
    .DATA_WIDTH (DATA_WIDTH),
    .ADDR_WIDTH (BUF_AW)
  ) u_ram (
    .wr_clk  (adc_clk),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (adc_wdata),
    .rd_clk  (axi_clk),
    .rd_addr (ram_rd_addr),
    .rd_data (ram_rd_data)
  );

  // axi_clk domain
  adcfifo_axi_writer #(
    .DATA_WIDTH (DATA_WIDTH),
    .BASE_ADDR  (BASE_ADDR)
  ) u_writer (
    .axi_clk      (axi_clk),
    .axi_resetn   (axi_resetn),
    .dma_xfer_req (dma_xfer_req),
    .waddr_gray   (waddr_gray),
    .rel_toggle   (rel_toggle),
    .rel_waddr    (rel_waddr),
    .rd_addr      (ram_rd_addr),
    .rd_data      (ram_rd_data),
    .beat_valid   (beat_valid),
    .beat_last    (beat_last),
    .beat_data    (beat_data),
    .beat_ready   (beat_ready),
    .awvalid      (awvalid),
    .awaddr       (awaddr),
    .awready      (awready),
    .bvalid       (bvalid),
    .bresp        (bresp),
    .werror       (werror),
    .dwovf        (dwovf),
    .dwunf        (dwunf),
    .rd_req       (rd_req),
    .rd_addr_out  (rd_addr)
  );

  adcfifo_wdata_skid #(
    .DATA_WIDTH (DATA_WIDTH)
  ) u_skid (
    .axi_clk    (axi_clk),
    .axi_resetn (axi_resetn),
    .beat_valid (beat_valid),
    .beat_last  (beat_last),
    .beat_data  (beat_data),
    .beat_ready (beat_ready),
    .wvalid     (wvalid),
    .wlast      (wlast),
    .wdata      (wdata),
    .wready     (wready)
  );

endmodule

/* verif/axi_mem_slave_model.sv */
`timescale 1ns/10ps

module axi_mem_slave_model #(
  parameter int          DATA_WIDTH = 64,
  parameter logic [31:0] SEED       = 32'h0000_0001
) (
  input  logic                   axi_clk,
  input  logic                   axi_resetn,
  input  logic                   awvalid,
  input  logic [31:0]            awaddr,
  output logic                   awready,
  input  logic                   wvalid,
  input  logic [DATA_WIDTH-1:0]  wdata,
  input  logic                   wlast,
  output logic                   wready,
  output logic                   bvalid,
  output adcfifo_pkg::axi_resp_e bresp,
  input  logic                   wready_hold,
  input  logic [31:0]            slverr_mask
);

  import adcfifo_pkg::*;

  logic [31:0]           aw_addr [0:255];
  logic [DATA_WIDTH-1:0] w_data  [0:1023];
  logic                  w_last  [0:1023];
  int                    aw_cnt    = 0;
  int                    w_cnt     = 0;
  int                    wlast_cnt = 0;
  int                    b_cnt     = 0;

  // handshakes recorded mid-cycle, bus is stable there
  always @(negedge axi_clk) begin
    if (axi_resetn) begin
      if (awvalid && awready) begin
        aw_addr[aw_cnt] = awaddr;
        aw_cnt = aw_cnt + 1;
      end
      if (wvalid && wready) begin
        w_data[w_cnt] = wdata;
        w_last[w_cnt] = wlast;
        w_cnt = w_cnt + 1;
        if (wlast) begin
          wlast_cnt = wlast_cnt + 1;
        end
      end
    end
  end

  // **********************************************************************
  // ready stalls and write responses
  // **********************************************************************

  initial begin
    awready = 1'b0;
    wready  = 1'b0;
    bvalid  = 1'b0;
    bresp   = OKAY;
    void'($urandom(SEED));
    forever begin
      @(posedge axi_clk);
      #1;
      awready = axi_resetn && (($urandom % 4) != 0);
      wready  = axi_resetn && !wready_hold && (($urandom % 3) != 0);
      bvalid  = 1'b0;
      bresp   = OKAY;
      // one response per burst, once its address and last beat are in
      if ((b_cnt < aw_cnt) && (b_cnt < wlast_cnt)) begin
        bvalid = 1'b1;
        bresp  = ((b_cnt < 32) && slverr_mask[b_cnt]) ? SLVERR : OKAY;
        b_cnt  = b_cnt + 1;
      end
    end
  end

endmodule

/* verif/tb_adcfifo_wr.sv */
`timescale 1ns/10ps

module tb_adcfifo_wr;

  localparam int          DATA_WIDTH  = 64;
  localparam int          BURST_BYTES = 4 * (DATA_WIDTH / 8);
  localparam logic [31:0] BASE_ADDR   = 32'h8000_1000;
  localparam logic [31:0] ADDR_LIMIT  = BASE_ADDR + 7 * BURST_BYTES;
  localparam int          MAX_BURSTS  = (ADDR_LIMIT - BASE_ADDR) / BURST_BYTES + 1;
  localparam logic [31:0] SEED        = 32'h7073e8b9;
  // bursts 1, 6 and 10 get SLVERR
  localparam logic [31:0] ERR_BURSTS  = 32'h0000_0442;
  localparam int          OVF_SAMPLES = 300;

  logic                   axi_clk;
  logic                   axi_resetn;
  logic                   adc_clk;
  logic                   adc_rst;
  logic                   dma_xfer_req;
  logic                   adc_wr;
  logic [DATA_WIDTH-1:0]  adc_wdata;
  logic                   awvalid;
  logic [31:0]            awaddr;
  logic                   awready;
  logic                   wvalid;
  logic [DATA_WIDTH-1:0]  wdata;
  logic                   wlast;
  logic                   wready;
  logic                   bvalid;
  adcfifo_pkg::axi_resp_e bresp;
  logic                   rd_req;
  logic [31:0]            rd_addr;
  logic                   werror;
  logic                   dwovf;
  logic                   dwunf;
  logic                   wready_hold;

  // reference model state
  logic [31:0] exp_tag [0:1023];
  logic [31:0] rd_list [0:255];
  int          exp_n         = 0;
  int          tag           = 0;
  int          rd_cnt        = 0;
  int          werror_cnt    = 0;
  int          dwovf_cnt     = 0;
  int          cycles        = 0;
  int          timeout_limit = 2000;
  int          errors        = 0;

  adcfifo_wr #(
    .DATA_WIDTH (DATA_WIDTH),
    .BASE_ADDR  (BASE_ADDR),
    .ADDR_LIMIT (ADDR_LIMIT)
  ) uut (
    .axi_clk      (axi_clk),
    .axi_resetn   (axi_resetn),
    .adc_clk      (adc_clk),
    .adc_rst      (adc_rst),
    .dma_xfer_req (dma_xfer_req),
    .adc_wr       (adc_wr),
    .adc_wdata    (adc_wdata),
    .awvalid      (awvalid),
    .awaddr       (awaddr),
    .awready      (awready),
    .wvalid       (wvalid),
    .wdata        (wdata),
    .wlast        (wlast),
    .wready       (wready),
    .bvalid       (bvalid),
    .bresp        (bresp),
    .rd_req       (rd_req),
    .rd_addr      (rd_addr),
    .werror       (werror),
    .dwovf        (dwovf),
    .dwunf        (dwunf)
  );

  axi_mem_slave_model #(
    .DATA_WIDTH (DATA_WIDTH),
    .SEED       (SEED)
  ) slave (
    .axi_clk     (axi_clk),
    .axi_resetn  (axi_resetn),
    .awvalid     (awvalid),
    .awaddr      (awaddr),
    .awready     (awready),
    .wvalid      (wvalid),
    .wdata       (wdata),
    .wlast       (wlast),
    .wready      (wready),
    .bvalid      (bvalid),
    .bresp       (bresp),
    .wready_hold (wready_hold),
    .slverr_mask (ERR_BURSTS)
  );

  initial begin
    axi_clk = 1'b0;
    forever #2 axi_clk = ~axi_clk;
  end

  initial begin
    adc_clk = 1'b0;
    forever #3.5 adc_clk = ~adc_clk;
  end

  // **********************************************************************
  // helpers
  // **********************************************************************

  task automatic abort_run;
    errors = errors + 1;
    $display("=== FAIL ===");
    $fatal(1, "run stopped at the first failure");
  endtask

  task automatic expect_equal(input string name, input logic [63:0] exp_v,
                              input logic [63:0] act_v);
    assert (exp_v === act_v) else begin
      $display("[ERROR] %s: expected %h, actual %h", name, exp_v, act_v);
      abort_run();
    end
  endtask

  // sample payload carries its tag twice
  function automatic logic [DATA_WIDTH-1:0] sample_word(input logic [31:0] t);
    return {t ^ 32'h5a3c_96e1, t};
  endfunction

  // whole groups up to the window limit
  function automatic int captured_samples(input int written);
    int groups;
    groups = (written + 3) / 4;
    if (groups > MAX_BURSTS) begin
      groups = MAX_BURSTS;
    end
    return groups * 4;
  endfunction

  task automatic expect_samples(input int first, input int n);
    for (int i = 0; i < n; i++) begin
      exp_tag[exp_n] = first + i;
      exp_n = exp_n + 1;
    end
  endtask

  task automatic start_request;
    @(posedge adc_clk);
    #1;
    dma_xfer_req = 1'b1;
    repeat (10) @(posedge adc_clk);
  endtask

  task automatic stop_request;
    @(posedge adc_clk);
    #1;
    dma_xfer_req = 1'b0;
    repeat (5) @(posedge adc_clk);
  endtask

  task automatic write_samples(input int n);
    for (int i = 0; i < n; i++) begin
      @(posedge adc_clk);
      #1;
      adc_wr    = 1'b1;
      adc_wdata = sample_word(tag);
      tag       = tag + 1;
    end
    @(posedge adc_clk);
    #1;
    adc_wr = 1'b0;
  endtask

  task automatic drain_and_check(input int aw_first, input int n_bursts);
    int n_aw;
    n_aw = aw_first + n_bursts;
    while ((slave.w_cnt < exp_n) || (slave.aw_cnt < n_aw) ||
           (slave.b_cnt < n_aw) || (rd_cnt < n_aw)) begin
      @(negedge axi_clk);
    end
    // extra beats would show up here
    repeat (60) @(negedge axi_clk);
    expect_equal("beat count", exp_n, slave.w_cnt);
    expect_equal("address count", n_aw, slave.aw_cnt);
    expect_equal("wlast count", n_aw, slave.wlast_cnt);
    expect_equal("rd_req count", n_aw, rd_cnt);
    for (int i = 0; i < exp_n; i++) begin
      expect_equal($sformatf("beat %0d wdata", i), sample_word(exp_tag[i]), slave.w_data[i]);
      expect_equal($sformatf("beat %0d wlast", i), (i % 4) == 3, slave.w_last[i]);
    end
    for (int k = 0; k < n_bursts; k++) begin
      expect_equal($sformatf("awaddr %0d", aw_first + k), BASE_ADDR + k * BURST_BYTES,
                   slave.aw_addr[aw_first + k]);
      expect_equal($sformatf("rd_addr %0d", aw_first + k), BASE_ADDR + k * BURST_BYTES,
                   rd_list[aw_first + k]);
    end
  endtask

  // status pulses and read requests
  always @(negedge axi_clk) begin
    if (axi_resetn) begin
      if (rd_req) begin
        rd_list[rd_cnt] = rd_addr;
        rd_cnt = rd_cnt + 1;
      end
      if (werror) begin
        werror_cnt = werror_cnt + 1;
      end
      if (dwovf) begin
        dwovf_cnt = dwovf_cnt + 1;
      end
    end
  end

  always @(posedge axi_clk) begin
    cycles = cycles + 1;
    if (cycles > timeout_limit) begin
      $display("timeout: run still busy after %0d axi_clk cycles", cycles);
      abort_run();
    end
  end

  // **********************************************************************
  // test sequence
  // **********************************************************************

  initial begin : run_tests
    int cap1;
    int cap2;
    int exp_werr;
    int ovf_written;
    axi_resetn    = 1'b0;
    adc_rst       = 1'b1;
    dma_xfer_req  = 1'b0;
    adc_wr        = 1'b0;
    adc_wdata     = '0;
    wready_hold   = 1'b0;
    cap1          = captured_samples(48);
    cap2          = captured_samples(22);
    timeout_limit = 20 * (cap1 + cap2) + 2000;
    fork
      begin
        repeat (10) @(posedge axi_clk);
        #1;
        axi_resetn = 1'b1;
      end
      begin
        repeat (10) @(posedge adc_clk);
        #1;
        adc_rst = 1'b0;
      end
    join

    // quiet until the first request
    repeat (40) begin
      @(negedge axi_clk);
      expect_equal("idle outputs", 6'b0, {awvalid, wvalid, rd_req, werror, dwovf, dwunf});
    end

    // window limit stops capture after MAX_BURSTS bursts
    expect_samples(tag, cap1);
    start_request();
    write_samples(48);
    stop_request();
    drain_and_check(0, cap1 / 4);

    // request dropped inside a group and addresses restart at the base
    expect_samples(tag, cap2);
    start_request();
    write_samples(22);
    stop_request();
    write_samples(12);
    drain_and_check(cap1 / 4, cap2 / 4);

    exp_werr = 0;
    for (int b = 0; b < (cap1 + cap2) / 4; b++) begin
      if (ERR_BURSTS[b]) begin
        exp_werr = exp_werr + 1;
      end
    end
    expect_equal("werror pulses", exp_werr, werror_cnt);
    expect_equal("dwovf pulses unstalled", 0, dwovf_cnt);

    // W channel held off until the writer laps the reader
    wready_hold = 1'b1;
    ovf_written = 0;
    while (ovf_written < OVF_SAMPLES) begin
      start_request();
      write_samples(MAX_BURSTS * 4);
      stop_request();
      ovf_written = ovf_written + MAX_BURSTS * 4;
    end
    repeat (20) @(negedge axi_clk);
    assert (dwovf_cnt > 0) else begin
      $display("overflow: dwovf never pulsed while the W channel was held off");
      abort_run();
    end

    if (errors == 0) begin
      $display("=== PASS ===");
      $finish;
    end else begin
      abort_run();
    end
  end

endmodule

/* sim.f */
hw/adcfifo_pkg.sv
hw/adcfifo_dual_port_ram.sv
hw/adcfifo_capture.sv
hw/adcfifo_axi_writer.sv
hw/adcfifo_wdata_skid.sv
hw/adcfifo_wr.sv
verif/axi_mem_slave_model.sv
verif/tb_adcfifo_wr.sv
